//--- hdl/adc_attach_pkg.sv
package adc_attach_pkg;

  // wishbone side widths
  localparam int WB_ADDR_W = 32;
  localparam int WB_DATA_W = 32;
  localparam int WB_SEL_W  = 4;   // byte selects, full word access only

  // word index lives in address bits 6..2
  localparam int ADDR_IDX_LSB = 2;
  localparam int ADDR_IDX_W   = 5;

  // bit positions inside status and mmcm control words
  localparam int STATUS_BUSY_BIT = 0;
  localparam int STATUS_LOCK_BIT = 8;
  localparam int MMCM_RST_BIT    = 0;
  localparam int MMCM_CLKSEL_BIT = 8;

  // register map, word index
  typedef enum logic [ADDR_IDX_W-1:0] {
    REG_DELAY_LOAD   = 5'd0,  // delay load lane mask
    REG_DELAY_RST    = 5'd1,  // delay reset lane mask
    REG_DELAY_VAL    = 5'd2,  // tap value for loads
    REG_STATUS       = 5'd3,  // busy, mmcm lock
    REG_ISERDES_RST  = 5'd4,
    REG_MMCM_CTRL    = 5'd5,  // reset bit 0, clksel bit 8
    REG_BITSLIP      = 5'd6,  // write only pulses
    REG_FCLK_ERR_CNT = 5'd7,
    REG_LCLK_CNT     = 5'd8,
    REG_FCLK_CNT     = 5'd9
  } wb_addr_e;

endpackage

//--- hdl/adc_lane_pkg.sv
package adc_lane_pkg;

  // lane topology, fixed at four units
  localparam int NUM_UNITS       = 4;
  localparam int LANES_PER_UNIT  = 4;
  localparam int NUM_DATA_LANES  = NUM_UNITS * LANES_PER_UNIT;   // 16
  localparam int NUM_FRAME_LANES = 1;
  localparam int NUM_TAP_LANES   = NUM_DATA_LANES + NUM_FRAME_LANES;  // 17, frame lane last

  // word and tap widths
  localparam int WORD_W     = 8;
  localparam int TAP_W      = 9;
  localparam int SLIP_W     = 3;   // rotation offset, wraps at 8
  localparam int LANE_IDX_W = 5;   // enough for 17 lanes
  localparam int CNT_W      = 32;  // link monitor counters

  // expected frame word during training
  localparam logic [WORD_W-1:0] FRAME_PATTERN = 8'hF0;

  // delay tap controller
  typedef enum logic [1:0] {
    DLY_IDLE = 2'd0,  // waiting for req
    DLY_SCAN = 2'd1,  // one lane per cycle
    DLY_ACK  = 2'd2   // hold ack until req drops
  } delay_state_e;

  typedef enum logic {
    OP_LOAD = 1'b0,  // write tap value
    OP_RST  = 1'b1   // clear tap to zero
  } delay_op_e;

endpackage

//--- hdl/wb_adc_regs.sv
`timescale 1ns/1ps

module wb_adc_regs (
  input  logic                                     wb_clk_i,
  input  logic                                     wb_rst_i,
  input  logic [adc_attach_pkg::WB_ADDR_W-1:0]     wb_adr_i,
  input  logic [adc_attach_pkg::WB_DATA_W-1:0]     wb_dat_i,
  input  logic [adc_attach_pkg::WB_SEL_W-1:0]      wb_sel_i,  // not honoured, word writes
  input  logic                                     wb_we_i,
  input  logic                                     wb_cyc_i,
  input  logic                                     wb_stb_i,
  output logic [adc_attach_pkg::WB_DATA_W-1:0]     wb_dat_o,
  output logic                                     wb_ack_o,
  input  logic                                     mmcm_locked_i,
  output logic                                     dly_req_o,
  output adc_lane_pkg::delay_op_e                  dly_op_o,
  output logic [adc_lane_pkg::NUM_TAP_LANES-1:0]   dly_mask_o,
  output logic [adc_lane_pkg::TAP_W-1:0]           dly_val_o,
  input  logic                                     dly_ack_i,
  output logic [adc_lane_pkg::NUM_DATA_LANES-1:0]  slip_pulse_o,
  output logic                                     cnt_clr_o,
  input  logic [adc_attach_pkg::WB_DATA_W-1:0]     err_cnt_i,
  input  logic [adc_attach_pkg::WB_DATA_W-1:0]     beat_cnt_i,
  input  logic [adc_attach_pkg::WB_DATA_W-1:0]     frame_cnt_i,
  output logic                                     iserdes_rst_o,
  output logic                                     mmcm_rst_o,
  output logic                                     mmcm_clksel_o
);
  import adc_attach_pkg::*;
  import adc_lane_pkg::*;

  wb_addr_e                  reg_idx;
  logic                      bus_req;      // new access this cycle
  logic                      wb_ack_q;
  logic [WB_DATA_W-1:0]      rd_mux;
  logic [WB_DATA_W-1:0]      rd_data_q;
  logic [NUM_TAP_LANES-1:0]  load_mask_q;
  logic [NUM_TAP_LANES-1:0]  rst_mask_q;
  logic [TAP_W-1:0]          delay_val_q;
  logic [TAP_W-1:0]          req_val_q;    // value frozen for the request
  logic                      dly_req_q;
  delay_op_e                 dly_op_q;
  logic                      dly_free;     // both handshake lines low
  logic                      busy;
  logic [NUM_DATA_LANES-1:0] slip_pulse_q;
  logic                      cnt_clr_q;
  logic                      iserdes_rst_q;
  logic                      mmcm_rst_q;
  logic                      mmcm_clksel_q;

  assign reg_idx  = wb_addr_e'(wb_adr_i[ADDR_IDX_LSB +: ADDR_IDX_W]);
  assign bus_req  = wb_cyc_i && wb_stb_i && !wb_ack_q;
  assign dly_free = !dly_req_q && !dly_ack_i;
  assign busy     = dly_req_q | dly_ack_i;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wb_ack_q      <= 1'b0;
      rd_data_q     <= '0;
      load_mask_q   <= '0;
      rst_mask_q    <= '0;
      delay_val_q   <= '0;
      req_val_q     <= '0;
      dly_req_q     <= 1'b0;
      dly_op_q      <= OP_LOAD;
      slip_pulse_q  <= '0;
      cnt_clr_q     <= 1'b0;
      iserdes_rst_q <= 1'b0;
      mmcm_rst_q    <= 1'b0;
      mmcm_clksel_q <= 1'b0;
    end else begin
      wb_ack_q     <= 1'b0;  // single cycle strobes
      slip_pulse_q <= '0;
      cnt_clr_q    <= 1'b0;
      if (dly_ack_i) begin
        dly_req_q <= 1'b0;   // phase 3, release request
      end
      if (bus_req) begin
        wb_ack_q  <= 1'b1;
        rd_data_q <= wb_we_i ? '0 : rd_mux;
        if (wb_we_i) begin
          case (reg_idx)
            REG_DELAY_LOAD: begin
              if (dly_free) begin  // dropped while busy
                load_mask_q <= wb_dat_i[NUM_TAP_LANES-1:0];
                req_val_q   <= delay_val_q;
                dly_op_q    <= OP_LOAD;
                dly_req_q   <= 1'b1;
              end
            end
            REG_DELAY_RST: begin
              if (dly_free) begin
                rst_mask_q <= wb_dat_i[NUM_TAP_LANES-1:0];
                dly_op_q   <= OP_RST;
                dly_req_q  <= 1'b1;
              end
            end
            REG_DELAY_VAL:   delay_val_q   <= wb_dat_i[TAP_W-1:0];
            REG_ISERDES_RST: iserdes_rst_q <= wb_dat_i[0];
            REG_MMCM_CTRL: begin
              mmcm_rst_q    <= wb_dat_i[MMCM_RST_BIT];
              mmcm_clksel_q <= wb_dat_i[MMCM_CLKSEL_BIT];
            end
            REG_BITSLIP:      slip_pulse_q <= wb_dat_i[NUM_DATA_LANES-1:0];
            REG_FCLK_ERR_CNT: cnt_clr_q    <= 1'b1;  // any counter write clears all
            REG_LCLK_CNT:     cnt_clr_q    <= 1'b1;
            REG_FCLK_CNT:     cnt_clr_q    <= 1'b1;
            default: ;
          endcase
        end
      end
    end
  end

  // read mux, unused bits zero
  always_comb begin
    rd_mux = '0;
    case (reg_idx)
      REG_DELAY_LOAD: rd_mux[NUM_TAP_LANES-1:0] = load_mask_q;
      REG_DELAY_RST:  rd_mux[NUM_TAP_LANES-1:0] = rst_mask_q;
      REG_DELAY_VAL:  rd_mux[TAP_W-1:0]         = delay_val_q;
      REG_STATUS: begin
        rd_mux[STATUS_BUSY_BIT] = busy;
        rd_mux[STATUS_LOCK_BIT] = mmcm_locked_i;
      end
      REG_ISERDES_RST: rd_mux[0] = iserdes_rst_q;
      REG_MMCM_CTRL: begin
        rd_mux[MMCM_RST_BIT]    = mmcm_rst_q;
        rd_mux[MMCM_CLKSEL_BIT] = mmcm_clksel_q;
      end
      REG_FCLK_ERR_CNT: rd_mux = err_cnt_i;
      REG_LCLK_CNT:     rd_mux = beat_cnt_i;
      REG_FCLK_CNT:     rd_mux = frame_cnt_i;
      default:          rd_mux = '0;  // bitslip and unmapped
    endcase
  end

  assign wb_dat_o      = wb_ack_q ? rd_data_q : '0;
  assign wb_ack_o      = wb_ack_q;
  assign dly_req_o     = dly_req_q;
  assign dly_op_o      = dly_op_q;
  // masks cannot change while busy, so this stays stable under req
  assign dly_mask_o    = (dly_op_q == OP_LOAD) ? load_mask_q : rst_mask_q;
  assign dly_val_o     = req_val_q;
  assign slip_pulse_o  = slip_pulse_q;
  assign cnt_clr_o     = cnt_clr_q;
  assign iserdes_rst_o = iserdes_rst_q;
  assign mmcm_rst_o    = mmcm_rst_q;
  assign mmcm_clksel_o = mmcm_clksel_q;

endmodule

//--- hdl/adc_delay_ctrl.sv
`timescale 1ns/1ps

module adc_delay_ctrl (
  input  logic                                                 wb_clk_i,
  input  logic                                                 wb_rst_i,
  input  logic                                                 dly_req_i,
  input  adc_lane_pkg::delay_op_e                              dly_op_i,
  input  logic [adc_lane_pkg::NUM_TAP_LANES-1:0]               dly_mask_i,
  input  logic [adc_lane_pkg::TAP_W-1:0]                       dly_val_i,
  output logic                                                 dly_ack_o,
  output logic [adc_lane_pkg::NUM_TAP_LANES*adc_lane_pkg::TAP_W-1:0] lane_tap_o
);
  import adc_lane_pkg::*;

  localparam logic [LANE_IDX_W-1:0] LAST_LANE = LANE_IDX_W'(NUM_TAP_LANES - 1);

  delay_state_e          state_q;
  logic [LANE_IDX_W-1:0] lane_idx_q;
  logic [TAP_W-1:0]      tap_q [NUM_TAP_LANES];
  logic                  scan_en;  // lane_idx_q is being visited
  logic [TAP_W-1:0]      wr_val;

  // lane 0 is handled on the cycle req is first seen, keeps latency at 17
  assign scan_en   = ((state_q == DLY_IDLE) && dly_req_i) || (state_q == DLY_SCAN);
  assign wr_val    = (dly_op_i == OP_LOAD) ? dly_val_i : '0;
  assign dly_ack_o = (state_q == DLY_ACK);

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state_q    <= DLY_IDLE;
      lane_idx_q <= '0;
    end else begin
      case (state_q)
        DLY_IDLE: begin
          if (dly_req_i) begin
            state_q    <= DLY_SCAN;
            lane_idx_q <= lane_idx_q + 1'b1;
          end
        end
        DLY_SCAN: begin
          if (lane_idx_q == LAST_LANE) begin
            state_q    <= DLY_ACK;  // ack rises with last lane written
            lane_idx_q <= '0;
          end else begin
            lane_idx_q <= lane_idx_q + 1'b1;
          end
        end
        DLY_ACK: begin
          if (!dly_req_i) begin
            state_q <= DLY_IDLE;    // phase 4, ack drops
          end
        end
        default: begin
          state_q    <= DLY_IDLE;
          lane_idx_q <= '0;
        end
      endcase
    end
  end

  // tap table, masked lanes only
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      for (int i = 0; i < NUM_TAP_LANES; i++) begin
        tap_q[i] <= '0;
      end
    end else if (scan_en && dly_mask_i[lane_idx_q]) begin
      tap_q[lane_idx_q] <= wr_val;
    end
  end

  // flatten, lane 16 is the frame lane
  for (genvar g = 0; g < NUM_TAP_LANES; g++) begin : g_tap_out
    assign lane_tap_o[g*TAP_W +: TAP_W] = tap_q[g];
  end

endmodule

//--- hdl/adc_bitslip_align.sv
`timescale 1ns/1ps

module adc_bitslip_align (
  input  logic                                                         wb_clk_i,
  input  logic                                                         wb_rst_i,
  input  logic [adc_lane_pkg::NUM_DATA_LANES-1:0]                      slip_pulse_i,
  input  logic                                                         adc_valid_i,
  input  logic [adc_lane_pkg::NUM_DATA_LANES*adc_lane_pkg::WORD_W-1:0] adc_data_i,
  output logic [adc_lane_pkg::NUM_DATA_LANES*adc_lane_pkg::WORD_W-1:0] aligned_data_o,
  output logic                                                         aligned_valid_o
);
  import adc_lane_pkg::*;

  logic [SLIP_W-1:0]                slip_off_q [NUM_DATA_LANES];  // per lane offset
  logic [NUM_DATA_LANES*WORD_W-1:0] data_q;
  logic                             valid_q;

  // rotate left through a doubled word
  function automatic logic [WORD_W-1:0] rotl(input logic [WORD_W-1:0] word,
                                             input logic [SLIP_W-1:0] off);
    logic [2*WORD_W-1:0] dbl;
    dbl = {word, word} << off;
    return dbl[2*WORD_W-1:WORD_W];
  endfunction

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      for (int i = 0; i < NUM_DATA_LANES; i++) begin
        slip_off_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_DATA_LANES; i++) begin
        if (slip_pulse_i[i]) begin
          slip_off_q[i] <= slip_off_q[i] + SLIP_W'(1);  // wraps at 8
        end
      end
    end
  end

  // word in this cycle uses the old offset, slip hits the next word
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      data_q  <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= adc_valid_i;
      if (adc_valid_i) begin
        for (int i = 0; i < NUM_DATA_LANES; i++) begin
          data_q[i*WORD_W +: WORD_W] <= rotl(adc_data_i[i*WORD_W +: WORD_W], slip_off_q[i]);
        end
      end
    end
  end

  assign aligned_data_o  = data_q;
  assign aligned_valid_o = valid_q;

endmodule

//--- hdl/adc_link_monitor.sv
`timescale 1ns/1ps

module adc_link_monitor (
  input  logic                             wb_clk_i,
  input  logic                             wb_rst_i,
  input  logic                             cnt_clr_i,
  input  logic                             adc_valid_i,
  input  logic [adc_lane_pkg::WORD_W-1:0]  adc_frame_i,
  output logic [adc_lane_pkg::CNT_W-1:0]   beat_cnt_o,
  output logic [adc_lane_pkg::CNT_W-1:0]   frame_cnt_o,
  output logic [adc_lane_pkg::CNT_W-1:0]   err_cnt_o
);
  import adc_lane_pkg::*;

  logic [CNT_W-1:0] beat_q;   // every valid beat
  logic [CNT_W-1:0] frame_q;  // beats with a nonzero frame word
  logic [CNT_W-1:0] err_q;    // frame word off pattern
  logic             frame_seen;
  logic             frame_bad;

  assign frame_seen = adc_valid_i && (adc_frame_i != '0);
  assign frame_bad  = adc_valid_i && (adc_frame_i != FRAME_PATTERN);

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i || cnt_clr_i) begin  // clear wins over a beat
      beat_q  <= '0;
      frame_q <= '0;
      err_q   <= '0;
    end else begin
      if (adc_valid_i) begin
        beat_q <= beat_q + 1'b1;      // free wrap
      end
      if (frame_seen) begin
        frame_q <= frame_q + 1'b1;
      end
      if (frame_bad) begin
        err_q <= err_q + 1'b1;        // zero word also counts as error
      end
    end
  end

  assign beat_cnt_o  = beat_q;
  assign frame_cnt_o = frame_q;
  assign err_cnt_o   = err_q;

endmodule

//--- hdl/adc_attach_top.sv
`timescale 1ns/1ps

module adc_attach_top (
  input  logic                                                         wb_clk_i,
  input  logic                                                         wb_rst_i,
  input  logic [adc_attach_pkg::WB_ADDR_W-1:0]                         wb_adr_i,
  input  logic [adc_attach_pkg::WB_DATA_W-1:0]                         wb_dat_i,
  input  logic [adc_attach_pkg::WB_SEL_W-1:0]                          wb_sel_i,
  input  logic                                                         wb_we_i,
  input  logic                                                         wb_cyc_i,
  input  logic                                                         wb_stb_i,
  output logic [adc_attach_pkg::WB_DATA_W-1:0]                         wb_dat_o,
  output logic                                                         wb_ack_o,
  input  logic                                                         mmcm_locked_i,
  input  logic                                                         adc_valid_i,
  input  logic [adc_lane_pkg::NUM_DATA_LANES*adc_lane_pkg::WORD_W-1:0] adc_data_i,
  input  logic [adc_lane_pkg::WORD_W-1:0]                              adc_frame_i,
  output logic [adc_lane_pkg::NUM_DATA_LANES*adc_lane_pkg::WORD_W-1:0] aligned_data_o,
  output logic                                                         aligned_valid_o,
  output logic [adc_lane_pkg::NUM_TAP_LANES*adc_lane_pkg::TAP_W-1:0]   lane_tap_o,
  output logic                                                         iserdes_rst_o,
  output logic                                                         mmcm_rst_o,
  output logic                                                         mmcm_clksel_o
);
  import adc_lane_pkg::*;

  // delay handshake
  logic                      dly_req;
  delay_op_e                 dly_op;
  logic [NUM_TAP_LANES-1:0]  dly_mask;
  logic [TAP_W-1:0]          dly_val;
  logic                      dly_ack;
  // aligner and monitor control
  logic [NUM_DATA_LANES-1:0] slip_pulse;
  logic                      cnt_clr;
  logic [CNT_W-1:0]          err_cnt;
  logic [CNT_W-1:0]          beat_cnt;
  logic [CNT_W-1:0]          frame_cnt;

  wb_adc_regs wb_adc_regs_inst (
    .wb_clk_i, .wb_rst_i, .wb_adr_i, .wb_dat_i, .wb_sel_i, .wb_we_i,
    .wb_cyc_i, .wb_stb_i, .wb_dat_o, .wb_ack_o, .mmcm_locked_i,
    .dly_req_o(dly_req), .dly_op_o(dly_op), .dly_mask_o(dly_mask),
    .dly_val_o(dly_val), .dly_ack_i(dly_ack),
    .slip_pulse_o(slip_pulse), .cnt_clr_o(cnt_clr),
    .err_cnt_i(err_cnt), .beat_cnt_i(beat_cnt), .frame_cnt_i(frame_cnt),
    .iserdes_rst_o, .mmcm_rst_o, .mmcm_clksel_o
  );

  adc_delay_ctrl adc_delay_ctrl_inst (
    .wb_clk_i, .wb_rst_i,
    .dly_req_i(dly_req), .dly_op_i(dly_op), .dly_mask_i(dly_mask),
    .dly_val_i(dly_val), .dly_ack_o(dly_ack),
    .lane_tap_o
  );

  adc_bitslip_align adc_bitslip_align_inst (
    .wb_clk_i, .wb_rst_i,
    .slip_pulse_i(slip_pulse),
    .adc_valid_i, .adc_data_i,
    .aligned_data_o, .aligned_valid_o
  );

  adc_link_monitor adc_link_monitor_inst (
    .wb_clk_i, .wb_rst_i,
    .cnt_clr_i(cnt_clr),
    .adc_valid_i, .adc_frame_i,
    .beat_cnt_o(beat_cnt), .frame_cnt_o(frame_cnt), .err_cnt_o(err_cnt)
  );

endmodule

//--- verification/adc_clk_gen.sv
`timescale 1ns/1ps

module adc_clk_gen (
  output logic clk_o,
  output logic rst_o
);
  localparam int RST_CYCLES = 16;

  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;  // 40 ns period
  end

  initial begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_o <= 1'b0;  // released on an edge like any other input
  end

endmodule

//--- verification/adc_attach_checker.sv
`timescale 1ns/1ps

module adc_attach_checker (
  input  logic                                                         clk_i,
  input  logic                                                         rst_i,
  input  logic [adc_attach_pkg::WB_ADDR_W-1:0]                         adr_i,  // bus snoop
  input  logic [adc_attach_pkg::WB_DATA_W-1:0]                         wdat_i,
  input  logic                                                         we_i,
  input  logic [adc_attach_pkg::WB_DATA_W-1:0]                         rdat_i,
  input  logic                                                         ack_i,
  input  logic                                                         locked_i,
  input  logic                                                         valid_i,  // lane stream
  input  logic [adc_lane_pkg::NUM_DATA_LANES*adc_lane_pkg::WORD_W-1:0] data_i,
  input  logic [adc_lane_pkg::WORD_W-1:0]                              frame_i,
  input  logic [adc_lane_pkg::NUM_DATA_LANES*adc_lane_pkg::WORD_W-1:0] aligned_i,
  input  logic                                                         aligned_valid_i,
  input  logic [adc_lane_pkg::NUM_TAP_LANES*adc_lane_pkg::TAP_W-1:0]   tap_i,
  input  logic                                                         iserdes_rst_i,
  input  logic                                                         mmcm_rst_i,
  input  logic                                                         mmcm_clksel_i,
  output int                                                           error_count_o
);
  import adc_attach_pkg::*;
  import adc_lane_pkg::*;

  localparam int BUSY_CYCLES = 19;  // 17 scan cycles, then req and ack fall

  logic [NUM_TAP_LANES-1:0]        load_mask_m, rst_mask_m;
  logic [TAP_W-1:0]                delay_val_m;
  logic                            iserdes_m, mmcm_rst_m, clksel_m;
  logic [NUM_TAP_LANES*TAP_W-1:0]  tap_m;
  int                              busy_left;    // cycles of busy still to come
  logic                            busy_prev;    // busy as the DUT saw it last cycle
  logic [SLIP_W-1:0]               off_m [NUM_DATA_LANES];
  logic [NUM_DATA_LANES-1:0]       slip_pend;
  logic [NUM_DATA_LANES*WORD_W-1:0] exp_data;
  logic                            exp_valid, ack_prev;
  logic [CNT_W-1:0]                beat_m, frame_m, err_m;
  int                              errors = 0;
  wb_addr_e                        idx;

  assign idx           = wb_addr_e'(adr_i[ADDR_IDX_LSB +: ADDR_IDX_W]);
  assign error_count_o = errors;

  // taps after one accepted delay request
  function automatic logic [NUM_TAP_LANES*TAP_W-1:0] tap_after(
      input logic [NUM_TAP_LANES*TAP_W-1:0] taps, input logic clear,
      input logic [NUM_TAP_LANES-1:0] mask, input logic [TAP_W-1:0] val);
    for (int l = 0; l < NUM_TAP_LANES; l++) begin
      if (mask[l]) taps[l*TAP_W +: TAP_W] = clear ? '0 : val;
    end
    return taps;
  endfunction

  function automatic logic [WORD_W-1:0] rot_ref(input logic [WORD_W-1:0] w, input int off);
    for (int s = 0; s < off; s++) begin
      w = {w[WORD_W-2:0], w[WORD_W-1]};  // one bit left per step
    end
    return w;
  endfunction

  // {beat, frame, err} increments of one valid beat
  function automatic logic [2:0] cnt_step(input logic [WORD_W-1:0] fw);
    return {1'b1, fw != '0, fw != FRAME_PATTERN};
  endfunction

  function automatic logic [WB_DATA_W-1:0] exp_read(input wb_addr_e a, input logic busy);
    logic [WB_DATA_W-1:0] d;
    d = '0;
    case (a)
      REG_DELAY_LOAD:   d[NUM_TAP_LANES-1:0] = load_mask_m;
      REG_DELAY_RST:    d[NUM_TAP_LANES-1:0] = rst_mask_m;
      REG_DELAY_VAL:    d[TAP_W-1:0]         = delay_val_m;
      REG_STATUS:       d = {23'd0, locked_i, 7'd0, busy};
      REG_ISERDES_RST:  d[0] = iserdes_m;
      REG_MMCM_CTRL:    d = {23'd0, clksel_m, 7'd0, mmcm_rst_m};
      REG_FCLK_ERR_CNT: d = err_m;
      REG_LCLK_CNT:     d = beat_m;
      REG_FCLK_CNT:     d = frame_m;
      default:          d = '0;
    endcase
    return d;
  endfunction

  task automatic fail_check(input string msg);
    errors++;
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
  endtask

  // everything sampled mid cycle, away from the rising edge
  always @(negedge clk_i) begin : compare
    logic                      busy_now;
    logic [WB_DATA_W-1:0]      exp;
    logic [NUM_DATA_LANES-1:0] slip_new;
    logic [2:0]                step;
    if (rst_i) begin
      {load_mask_m, rst_mask_m, delay_val_m, tap_m} = '0;
      {iserdes_m, mmcm_rst_m, clksel_m, busy_prev, exp_valid, ack_prev} = '0;
      {beat_m, frame_m, err_m, slip_pend} = '0;
      busy_left = 0;
      for (int l = 0; l < NUM_DATA_LANES; l++) off_m[l] = '0;
    end else begin
      slip_new = '0;
      if (busy_left > 0) busy_left--;
      if (valid_i) begin  // counted on the next edge
        step    = cnt_step(frame_i);
        beat_m  = beat_m + step[2];
        frame_m = frame_m + step[1];
        err_m   = err_m + step[0];
      end
      if (ack_i && ack_prev) fail_check("wb_ack_o high for two cycles");
      if (ack_i) begin
        exp = we_i ? '0 : exp_read(idx, busy_prev);  // data captured last cycle
        if (rdat_i !== exp) fail_check($sformatf("index %0d read %h, expected %h",
                                                 idx, rdat_i, exp));
      end
      if (ack_i && we_i) begin
        case (idx)
          REG_DELAY_LOAD, REG_DELAY_RST: begin
            if (!busy_prev) begin  // busy writes are dropped
              if (idx == REG_DELAY_LOAD) load_mask_m = wdat_i[NUM_TAP_LANES-1:0];
              else rst_mask_m = wdat_i[NUM_TAP_LANES-1:0];
              tap_m = tap_after(tap_m, idx == REG_DELAY_RST, wdat_i[NUM_TAP_LANES-1:0],
                                delay_val_m);
              busy_left = BUSY_CYCLES;
            end
          end
          REG_DELAY_VAL:   delay_val_m = wdat_i[TAP_W-1:0];
          REG_ISERDES_RST: iserdes_m = wdat_i[0];
          REG_MMCM_CTRL:   {clksel_m, mmcm_rst_m} = {wdat_i[8], wdat_i[0]};
          REG_BITSLIP:     slip_new = wdat_i[NUM_DATA_LANES-1:0];
          REG_FCLK_ERR_CNT, REG_LCLK_CNT, REG_FCLK_CNT: {beat_m, frame_m, err_m} = '0;
          default: ;
        endcase
      end
      busy_now = busy_left > 0;
      if (busy_prev && !busy_now && tap_i !== tap_m)
        fail_check($sformatf("lane taps %h, expected %h", tap_i, tap_m));
      if ({iserdes_rst_i, mmcm_rst_i, mmcm_clksel_i} !== {iserdes_m, mmcm_rst_m, clksel_m})
        fail_check("control outputs differ from written registers");
      if (aligned_valid_i !== exp_valid) fail_check("aligned_valid_o wrong");
      else if (exp_valid && aligned_i !== exp_data)
        fail_check($sformatf("aligned word %h, expected %h", aligned_i, exp_data));
      for (int l = 0; l < NUM_DATA_LANES; l++) begin
        if (slip_pend[l]) off_m[l] = off_m[l] + 1'b1;  // wraps at 8
      end
      exp_valid = valid_i;
      for (int l = 0; l < NUM_DATA_LANES && valid_i; l++) begin
        exp_data[l*WORD_W +: WORD_W] = rot_ref(data_i[l*WORD_W +: WORD_W], off_m[l]);
      end
      slip_pend = slip_new;  // offsets move one edge after the pulse
      ack_prev  = ack_i;
      busy_prev = busy_now;
    end
  end

endmodule

//--- verification/tb_adc_attach.sv
`timescale 1ns/1ps

module tb_adc_attach;
  import adc_attach_pkg::*;
  import adc_lane_pkg::*;

  logic                             clk, rst;
  logic [WB_ADDR_W-1:0]             wb_adr_i;
  logic [WB_DATA_W-1:0]             wb_dat_i, wb_dat_o, rd;
  logic [WB_SEL_W-1:0]              wb_sel_i;
  logic                             wb_we_i, wb_cyc_i, wb_stb_i, wb_ack_o, mmcm_locked_i;
  logic                             adc_valid_i, aligned_valid_o;
  logic [NUM_DATA_LANES*WORD_W-1:0] adc_data_i, aligned_data_o;
  logic [WORD_W-1:0]                adc_frame_i;
  logic [NUM_TAP_LANES*TAP_W-1:0]   lane_tap_o;
  logic                             iserdes_rst_o, mmcm_rst_o, mmcm_clksel_o;
  int                               check_errors, errors_before, tests_run, tests_failed;
  int                               cycle = 0;

  adc_clk_gen clk_gen_inst (.clk_o(clk), .rst_o(rst));

  adc_attach_top adc_attach_top_inst (.wb_clk_i(clk), .wb_rst_i(rst), .*);

  adc_attach_checker checker_inst (
    .clk_i(clk), .rst_i(rst), .adr_i(wb_adr_i), .wdat_i(wb_dat_i), .we_i(wb_we_i),
    .rdat_i(wb_dat_o), .ack_i(wb_ack_o), .locked_i(mmcm_locked_i),
    .valid_i(adc_valid_i), .data_i(adc_data_i), .frame_i(adc_frame_i),
    .aligned_i(aligned_data_o), .aligned_valid_i(aligned_valid_o), .tap_i(lane_tap_o),
    .iserdes_rst_i(iserdes_rst_o), .mmcm_rst_i(mmcm_rst_o), .mmcm_clksel_i(mmcm_clksel_o),
    .error_count_o(check_errors)
  );

  always @(posedge clk) cycle <= cycle + 1;

  task automatic abort_on_timeout(input string what);
    $display("TIMEOUT: no response while %s", what);
    $display("Some tests failed");
    $finish;
  endtask

  task automatic wait_reset_done();
    int waited;
    waited = 0;
    while (rst && waited < 100) begin
      @(posedge clk);
      waited++;
    end
    if (rst) abort_on_timeout("waiting for reset release");
  endtask

  // classic single access, cyc and stb held until ack
  task automatic wb_access(input logic we, input logic [4:0] idx,
                           input logic [WB_DATA_W-1:0] data, output logic [WB_DATA_W-1:0] rdata);
    int waited;
    waited = 0;
    @(posedge clk);
    wb_adr_i <= WB_ADDR_W'({idx, 2'b00});
    wb_dat_i <= data;
    wb_we_i  <= we;
    {wb_cyc_i, wb_stb_i} <= 2'b11;
    do begin
      @(posedge clk);
      waited++;
    end while (!wb_ack_o && waited < 50);
    if (!wb_ack_o) begin
      abort_on_timeout("waiting for wb_ack_o");
    end else begin
      rdata = wb_dat_o;
      {wb_cyc_i, wb_stb_i, wb_we_i} <= 3'b000;
    end
  endtask

  task automatic wb_write(input logic [4:0] idx, input logic [WB_DATA_W-1:0] data);
    logic [WB_DATA_W-1:0] unused;
    wb_access(1'b1, idx, data, unused);
  endtask

  task automatic wb_read(input logic [4:0] idx);
    wb_access(1'b0, idx, '0, rd);  // value judged by the checker
  endtask

  // skew shifts the poll phase against the busy window
  task automatic wait_idle(input int skew);
    int start;
    start = cycle;
    repeat (skew) @(posedge clk);
    do wb_read(REG_STATUS); while (rd[STATUS_BUSY_BIT] && cycle - start < 200);
    if (rd[STATUS_BUSY_BIT]) abort_on_timeout("polling the busy bit");
  endtask

  // random beats, frame words mixed from pattern, zero and noise
  task automatic stream_beats(input int beats);
    int sel;
    for (int n = 0; n < beats; n++) begin
      @(posedge clk);
      sel = $urandom % 3;
      adc_valid_i <= ($urandom % 4) != 0;
      adc_data_i  <= {$urandom, $urandom, $urandom, $urandom};
      adc_frame_i <= (sel == 0) ? FRAME_PATTERN : (sel == 1) ? 8'h00 : 8'($urandom);
    end
    @(posedge clk);
    adc_valid_i <= 1'b0;
  endtask

  task automatic finish_test(input string name);
    repeat (2) @(posedge clk);  // last outputs reach the checker
    tests_run++;
    if (check_errors == errors_before) begin
      $display("test %-14s ok", name);
    end else begin
      tests_failed++;
      $display("test %-14s %0d mismatches", name, check_errors - errors_before);
    end
    errors_before = check_errors;
  endtask

  initial begin
    void'($urandom(88555));
    {wb_adr_i, wb_dat_i, adc_data_i, adc_frame_i} <= '0;
    {wb_we_i, wb_cyc_i, wb_stb_i, adc_valid_i} <= 4'b0000;
    wb_sel_i      <= '1;
    mmcm_locked_i <= 1'($urandom);
    {errors_before, tests_run, tests_failed} = '0;
    wait_reset_done();
    wb_write(REG_DELAY_VAL, $urandom);
    wb_write(REG_ISERDES_RST, $urandom);
    wb_write(REG_MMCM_CTRL, $urandom);
    wb_read(REG_DELAY_VAL);
    wb_read(REG_ISERDES_RST);
    wb_read(REG_MMCM_CTRL);
    wb_read(REG_STATUS);
    mmcm_locked_i <= ~mmcm_locked_i;  // lock bit seen at both levels
    wb_read(REG_STATUS);
    wb_read(5'(10 + $urandom % 22));  // unmapped indices
    finish_test("register map");
    for (int k = 0; k < 3; k++) begin  // later loads overlay earlier ones
      wb_write(REG_DELAY_VAL, $urandom);
      wb_write(REG_DELAY_LOAD, $urandom);
      wait_idle(k);  // polls land on each cycle around the busy fall
    end
    wb_write(REG_DELAY_RST, $urandom);
    wait_idle(0);
    wb_read(REG_DELAY_LOAD);
    wb_read(REG_DELAY_RST);
    finish_test("delay taps");
    wb_write(REG_DELAY_VAL, $urandom);
    wb_write(REG_DELAY_LOAD, $urandom);
    wb_write(REG_DELAY_VAL, $urandom);
    wb_write(REG_DELAY_LOAD, $urandom);  // lands while busy
    wait_idle(0);
    wb_read(REG_DELAY_LOAD);
    finish_test("busy drop");
    fork
      stream_beats(300);
      repeat (6) begin
        repeat (10 + $urandom % 20) @(posedge clk);
        wb_write(REG_BITSLIP, $urandom);
      end
    join
    finish_test("bitslip");
    wb_write(REG_FCLK_CNT, '0);
    stream_beats(250);
    wb_read(REG_LCLK_CNT);
    wb_read(REG_FCLK_CNT);
    wb_read(REG_FCLK_ERR_CNT);
    wb_write(REG_LCLK_CNT, $urandom);
    wb_read(REG_LCLK_CNT);
    wb_read(REG_FCLK_CNT);
    wb_read(REG_FCLK_ERR_CNT);
    finish_test("link counters");
    $display("%0d tests, %0d failed, %0d check errors", tests_run, tests_failed, check_errors);
    if (tests_failed == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- adc_attach_top.f
hdl/adc_attach_pkg.sv
hdl/adc_lane_pkg.sv
hdl/wb_adc_regs.sv
hdl/adc_delay_ctrl.sv
hdl/adc_bitslip_align.sv
hdl/adc_link_monitor.sv
hdl/adc_attach_top.sv
verification/adc_clk_gen.sv
verification/adc_attach_checker.sv
verification/tb_adc_attach.sv

//--- Bender.yml
package:
  name: adc_attach

sources:
  - files:
      - hdl/adc_attach_pkg.sv
      - hdl/adc_lane_pkg.sv
      - hdl/wb_adc_regs.sv
      - hdl/adc_delay_ctrl.sv
      - hdl/adc_bitslip_align.sv
      - hdl/adc_link_monitor.sv
      - hdl/adc_attach_top.sv
  - target: test
    files:
      - verification/adc_clk_gen.sv
      - verification/adc_attach_checker.sv
      - verification/tb_adc_attach.sv
